/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cache_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = run.log
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail, the simulator exit code is not enough
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/cache_data_array.sv */
`timescale 1ns/10ps

module cache_data_array import cache_pkg::*; (
  input  logic              clk,
  input  logic              rd,        // register both ways
  input  logic              wr,        // write one word
  input  logic              way,       // write way, and read select
  input  logic [set_w-1:0]  set,
  input  logic [off_w-1:0]  word_off,
  input  logic [word_w-1:0] wdata,
  output logic [word_w-1:0] rdata
);

  localparam int depth = n_sets * beats;  // words per way

  logic [word_w-1:0]      mem [2][depth];
  logic [set_w+off_w-1:0] idx;

  logic [word_w-1:0] rd0_q;  // way 0 word
  logic [word_w-1:0] rd1_q;  // way 1 word

  // set selects the block, offset the word
  assign idx = {set, word_off};

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[way][idx] <= wdata;
    end
  end

  // both ways read together, tag result not known yet
  always_ff @(posedge clk) begin
    if (rd) begin
      rd0_q <= mem[0][idx];
      rd1_q <= mem[1][idx];
    end
  end

  // way comes from the registered hit way by now
  assign rdata = way ? rd1_q : rd0_q;

endmodule

/* logic/cache_fill_ctrl.sv */
`timescale 1ns/10ps

module cache_fill_ctrl import cache_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              cpu_req,
  input  logic              cpu_we,
  input  logic [addr_w-1:0] cpu_addr,
  input  logic [word_w-1:0] cpu_wdata,
  input  logic              hit,
  input  logic              mem_ack,
  input  logic [word_w-1:0] mem_rdata,
  input  logic [word_w-1:0] rdata,
  output logic              cpu_ack,
  output logic              cpu_miss,
  output logic [word_w-1:0] cpu_rdata,
  output logic              lookup,
  output logic              load_word,
  output logic              load_tag,
  output logic              write_hit,
  output logic              mem_req,
  output logic              mem_we,
  output logic [addr_w-1:0] mem_addr,
  output logic [word_w-1:0] mem_wdata,
  output logic [off_w-1:0]  fill_off
);

  logic [2:0]       state;
  logic             lk_done;   // second lookup cycle, hit is valid
  logic [off_w-1:0] beat_cnt;
  logic             last_beat;
  logic             decide;
  cache_addr_u      req_a;

  assign req_a.raw = cpu_addr;
  assign last_beat = (beat_cnt == off_w'(beats - 1));
  assign decide    = (state == st_lookup) && lk_done;

  // array strobes
  assign lookup    = (state == st_lookup) && !lk_done;
  assign write_hit = decide && cpu_we && hit;
  assign load_word = (state == st_fill_beat) && mem_ack;  // data valid with ack
  assign load_tag  = (state == st_fill_wait) && !mem_ack && last_beat;
  assign fill_off  = beat_cnt;

  // fill walks the block from word 0, write-through uses cpu address
  assign mem_addr  = (state == st_wt) ? cpu_addr
                   : {req_a.fields.tag, req_a.fields.set, beat_cnt, 1'b0};
  assign mem_wdata = cpu_wdata;  // held stable by the processor

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      lk_done  <= 1'b0;
      beat_cnt <= '0;
      cpu_ack  <= 1'b0;
      cpu_miss <= 1'b0;
      mem_req  <= 1'b0;
      mem_we   <= 1'b0;
    end else begin
      case (state)
        st_idle: if (cpu_req) begin
          state   <= st_lookup;
          lk_done <= 1'b0;
        end
        st_lookup: begin
          if (!lk_done) begin
            lk_done <= 1'b1;  // arrays registering
          end else begin
            cpu_miss <= ~hit;
            if (cpu_we) begin  // every write goes to memory
              state   <= st_wt;
              mem_req <= 1'b1;
              mem_we  <= 1'b1;
            end else if (hit) begin
              state <= st_resp;
            end else begin
              state    <= st_fill_beat;
              beat_cnt <= '0;
              mem_req  <= 1'b1;
            end
          end
        end
        st_fill_beat: if (mem_ack) begin
          mem_req <= 1'b0;
          state   <= st_fill_wait;
        end
        st_fill_wait: if (!mem_ack) begin  // beat closed
          if (last_beat) begin
            state <= st_resp;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
            mem_req  <= 1'b1;
            state    <= st_fill_beat;
          end
        end
        st_wt: begin
          if (mem_req && mem_ack) begin
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
          end else if (!mem_req && !mem_ack) begin
            state <= st_resp;
          end
        end
        st_resp: begin
          if (!cpu_ack) begin
            cpu_ack <= 1'b1;
          end else if (!cpu_req) begin  // four-phase close
            cpu_ack <= 1'b0;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // read data, from the array on a hit or from the burst on a miss
  always_ff @(posedge clk) begin
    if (decide && !cpu_we) cpu_rdata <= rdata;
    if (load_word && (beat_cnt == req_a.fields.word_off)) cpu_rdata <= mem_rdata;
  end

  // each beat waits for the previous ack to fall
  a_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(mem_req) |-> !$past(mem_ack));

endmodule

/* logic/cache_meta_array.sv */
`timescale 1ns/10ps

module cache_meta_array import cache_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             lookup,     // compare tags this cycle
  input  logic             load_tag,   // install tag in victim way
  input  logic             touch,      // update lru on a hit
  input  logic [tag_w-1:0] tag,
  input  logic [set_w-1:0] set,
  output logic             hit,        // registered, valid cycle after lookup
  output logic             hit_way,
  output logic             victim_way  // way a fill goes to
);

  logic [1:0][n_sets-1:0] valid_q;
  logic [n_sets-1:0]      lru_q;       // points at the way to evict next
  logic [tag_w-1:0]       tag_mem [2][n_sets];

  logic match0;
  logic match1;
  logic hit_c;

  assign match0 = valid_q[0][set] && (tag_mem[0][set] == tag);
  assign match1 = valid_q[1][set] && (tag_mem[1][set] == tag);
  assign hit_c  = match0 | match1;

  // empty set always starts in way 0
  assign victim_way = (valid_q[0][set] | valid_q[1][set]) ? lru_q[set] : 1'b0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      lru_q   <= '0;
      hit     <= 1'b0;
      hit_way <= 1'b0;
    end else begin
      if (lookup) begin
        hit     <= hit_c;
        hit_way <= match1;  // way 0 unless way 1 matched
      end
      if (load_tag) begin
        valid_q[victim_way][set] <= 1'b1;
        lru_q[set]               <= ~victim_way;  // new block is most recent
      end else if (touch && hit_c) begin
        lru_q[set] <= ~match1;
      end
    end
  end

  // tag store
  always_ff @(posedge clk) begin
    if (load_tag) tag_mem[victim_way][set] <= tag;
  end

  // a fill only ever goes to a way whose tag missed, so no duplicates
  a_one_way_hit: assert property (@(posedge clk) disable iff (!arst_n)
    lookup |-> !(match0 && match1));

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

  // geometry, fixed by the address split
  localparam int addr_w = 16;   // byte address
  localparam int word_w = 16;   // data word
  localparam int tag_w  = 6;
  localparam int set_w  = 6;
  localparam int n_sets = 64;
  localparam int off_w  = 3;    // word within block
  localparam int beats  = 8;    // words per block == burst length

  // controller state codes
  localparam logic [2:0] st_idle      = 3'd0;
  localparam logic [2:0] st_lookup    = 3'd1;
  localparam logic [2:0] st_fill_beat = 3'd2;
  localparam logic [2:0] st_fill_wait = 3'd3;
  localparam logic [2:0] st_wt        = 3'd4;   // write-through beat
  localparam logic [2:0] st_resp      = 3'd5;

  // one address word, seen either whole or split for the cache
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [tag_w-1:0] tag;       // 15:10
      logic [set_w-1:0] set;       // 9:4
      logic [off_w-1:0] word_off;  // 3:1
      logic             byte_sel;  // 0, unused for word access
    } fields;
  } cache_addr_u;

endpackage

/* logic/cache_top.sv */
`timescale 1ns/10ps

module cache_top import cache_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  // processor side
  input  logic              cpu_req,
  input  logic              cpu_we,
  input  logic [addr_w-1:0] cpu_addr,
  input  logic [word_w-1:0] cpu_wdata,
  output logic              cpu_ack,
  output logic [word_w-1:0] cpu_rdata,
  output logic              cpu_miss,
  // memory side
  output logic              mem_req,
  output logic              mem_we,
  output logic [addr_w-1:0] mem_addr,
  output logic [word_w-1:0] mem_wdata,
  input  logic              mem_ack,
  input  logic [word_w-1:0] mem_rdata
);

  logic              lookup;
  logic              load_word;
  logic              load_tag;
  logic              write_hit;
  logic              hit;
  logic [word_w-1:0] rdata;     // array word, hit path
  logic [off_w-1:0]  fill_off;

  d_cache d_cache_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .lookup    (lookup),
    .load_word (load_word),
    .load_tag  (load_tag),
    .write_hit (write_hit),
    .addr      (cpu_addr),
    .fill_off  (fill_off),
    .wdata     (cpu_wdata),
    .fill_data (mem_rdata),
    .hit       (hit),
    .rdata     (rdata)
  );

  cache_fill_ctrl ctrl_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cpu_req   (cpu_req),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .hit       (hit),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .rdata     (rdata),
    .cpu_ack   (cpu_ack),
    .cpu_miss  (cpu_miss),
    .cpu_rdata (cpu_rdata),
    .lookup    (lookup),
    .load_word (load_word),
    .load_tag  (load_tag),
    .write_hit (write_hit),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .fill_off  (fill_off)
  );

endmodule

/* logic/d_cache.sv */
`timescale 1ns/10ps

module d_cache import cache_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              lookup,
  input  logic              load_word,
  input  logic              load_tag,
  input  logic              write_hit,
  input  logic [addr_w-1:0] addr,
  input  logic [off_w-1:0]  fill_off,
  input  logic [word_w-1:0] wdata,
  input  logic [word_w-1:0] fill_data,
  output logic              hit,
  output logic [word_w-1:0] rdata
);

  cache_addr_u a;

  logic             hit_way;
  logic             victim_way;
  logic             filling;
  logic             way;
  logic [off_w-1:0] word_off;
  logic [word_w-1:0] din;

  assign a.raw = addr;

  // fill targets the victim, everything else the hit way
  assign filling  = load_word | load_tag;
  assign way      = filling ? victim_way : hit_way;
  assign word_off = load_word ? fill_off : a.fields.word_off;
  assign din      = load_word ? fill_data : wdata;  // burst word or cpu write

  cache_meta_array meta_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .lookup     (lookup),
    .load_tag   (load_tag),
    .touch      (lookup),      // lru follows every hit
    .tag        (a.fields.tag),
    .set        (a.fields.set),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  cache_data_array data_i (
    .clk      (clk),
    .rd       (lookup),
    .wr       (load_word | write_hit),
    .way      (way),
    .set      (a.fields.set),
    .word_off (word_off),
    .wdata    (din),
    .rdata    (rdata)
  );

  // a fill and a write hit never share a cycle, the mux above assumes it
  a_one_writer: assert property (@(posedge clk) disable iff (!arst_n)
    !(load_word && write_hit));

endmodule

/* tb.f */
logic/cache_pkg.sv
logic/cache_meta_array.sv
logic/cache_data_array.sv
logic/cache_fill_ctrl.sv
logic/d_cache.sv
logic/cache_top.sv
tb/tb_mem_model.sv
tb/tb_cache_top.sv

/* tb/tb_cache_top.sv */
`timescale 1ns/10ps

module tb_cache_top import cache_pkg::*; ();

  localparam int n_rand     = 400;
  localparam int n_directed = 12;
  localparam int max_cycles = (n_rand + n_directed) * 200;  // generous per transaction

  logic              clk;
  logic              arst_n;
  logic              cpu_req;
  logic              cpu_we;
  logic [addr_w-1:0] cpu_addr;
  logic [word_w-1:0] cpu_wdata;
  logic              cpu_ack;
  logic [word_w-1:0] cpu_rdata;
  logic              cpu_miss;
  logic              mem_req;
  logic              mem_we;
  logic [addr_w-1:0] mem_addr;
  logic [word_w-1:0] mem_wdata;
  logic              mem_ack;
  logic [word_w-1:0] mem_rdata;

  // reference model state
  logic [word_w-1:0] shadow [1 << (addr_w-1)];
  logic              ref_valid [n_sets][2];
  logic [tag_w-1:0]  ref_tag [n_sets][2];
  logic              ref_lru [n_sets];   // way to evict next

  // memory beats seen in the current transaction
  logic              beat_we_q [$];
  logic [addr_w-1:0] beat_addr_q [$];
  logic              ack_seen = 1'b0;

  int seed;
  int cycles;

  cache_top cache_top_i (.*);

  tb_mem_model mem_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    abort_run($sformatf("timeout, run not finished after %0d cycles", max_cycles));
  end

  // one entry per beat taken on the rise of mem_ack
  always @(negedge clk) begin
    if (mem_ack && !ack_seen) begin
      beat_we_q.push_back(mem_we);
      beat_addr_q.push_back(mem_addr);
    end
    ack_seen = mem_ack;
  end

  task automatic check_word(input string name, input logic [word_w-1:0] got,
                            input logic [word_w-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED t=%0t %s got 0x%h exp 0x%h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                            input logic [addr_w-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED t=%0t %s got 0x%h exp 0x%h", $time, name, got, exp));
  endtask

  function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] tag,
      input logic [set_w-1:0] set, input logic [off_w-1:0] off);
    cache_addr_u a;
    a.raw            = '0;
    a.fields.tag      = tag;
    a.fields.set      = set;
    a.fields.word_off = off;
    return a.raw;
  endfunction

  // read miss fills lru or empty way, hit touches, writes never allocate
  task automatic model_access(input logic we, input logic [addr_w-1:0] addr,
                              input logic [word_w-1:0] wdata,
                              output logic hit, output logic [word_w-1:0] data);
    cache_addr_u      a;
    logic [set_w-1:0] s;
    logic             h0;
    logic             h1;
    logic             victim;
    a.raw = addr;
    s     = a.fields.set;
    h0    = ref_valid[s][1'b0] && (ref_tag[s][1'b0] == a.fields.tag);
    h1    = ref_valid[s][1'b1] && (ref_tag[s][1'b1] == a.fields.tag);
    hit   = h0 | h1;
    if (hit) ref_lru[s] = h1 ? 1'b0 : 1'b1;  // the other way goes next
    if (we) begin
      shadow[a.raw[addr_w-1:1]] = wdata;      // write-through keeps cache and memory equal
    end else if (!hit) begin
      victim                = (ref_valid[s][1'b0] || ref_valid[s][1'b1]) ? ref_lru[s] : 1'b0;
      ref_valid[s][victim]  = 1'b1;
      ref_tag[s][victim]    = a.fields.tag;
      ref_lru[s]            = ~victim;
    end
    data = shadow[a.raw[addr_w-1:1]];
  endtask

  // want_miss is 0 or 1 for a directed expectation or -1 when only the model counts
  task automatic run_txn(input logic we, input logic [addr_w-1:0] addr,
                         input logic [word_w-1:0] wdata, input int want_miss);
    cache_addr_u       a;
    logic              exp_hit;
    logic [word_w-1:0] exp_data;
    logic              got_miss;
    logic [word_w-1:0] got_data;
    int                lat;
    int                n_exp;
    a.raw = addr;
    model_access(we, addr, wdata, exp_hit, exp_data);
    beat_we_q.delete();
    beat_addr_q.delete();
    @(posedge clk);
    cpu_req   <= 1'b1;
    cpu_we    <= we;
    cpu_addr  <= addr;
    cpu_wdata <= wdata;
    lat = -1;  // DUT samples req on the first edge
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (!cpu_ack);
    got_miss = cpu_miss;
    got_data = cpu_rdata;
    @(posedge clk);
    cpu_req <= 1'b0;
    do begin
      @(negedge clk);
    end while (cpu_ack);
    check_bit("cpu_miss", got_miss, !exp_hit);
    if (want_miss >= 0) check_bit("cpu_miss (directed)", got_miss, want_miss[0]);
    if (!we) check_word("cpu_rdata", got_data, exp_data);
    if (!we && exp_hit && lat != 3)
      abort_run($sformatf("read hit acknowledged %0d cycles after request, expected 3", lat));
    n_exp = we ? 1 : (exp_hit ? 0 : beats);
    if (beat_we_q.size() != n_exp)
      abort_run($sformatf("wrong number of memory beats for 0x%h, saw %0d, expected %0d",
                          addr, beat_we_q.size(), n_exp));
    foreach (beat_addr_q[i]) begin
      check_bit("mem_we", beat_we_q[i], we);
      if (we) check_addr("mem_addr", beat_addr_q[i], addr);
      else check_addr("mem_addr", beat_addr_q[i],  // block base plus two bytes per beat
                      make_addr(a.fields.tag, a.fields.set, 3'd0) + addr_w'(2 * i));
    end
    if (we) check_word("memory word", mem_i.mem[a.raw[addr_w-1:1]], exp_data);
  endtask

  initial begin
    logic [1:0] tsel;
    logic       we;
    int         r;
    seed      = 58685;
    arst_n    = 1'b0;
    cpu_req   = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    ref_valid = '{default: '0};
    ref_tag   = '{default: '0};
    ref_lru   = '{default: 1'b0};
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    shadow = mem_i.mem;  // memory model contents after its fill

    // cold miss then hit in the same block
    run_txn(1'b0, make_addr(6'h01, 6'd9, 3'd3), 16'h0, 1);
    run_txn(1'b0, make_addr(6'h01, 6'd9, 3'd5), 16'h0, 0);
    // third tag into set 9 evicts the lru way
    run_txn(1'b0, make_addr(6'h02, 6'd9, 3'd0), 16'h0, 1);
    run_txn(1'b0, make_addr(6'h01, 6'd9, 3'd1), 16'h0, 0);   // tag 1 most recent
    run_txn(1'b0, make_addr(6'h03, 6'd9, 3'd2), 16'h0, 1);   // tag 2 out
    run_txn(1'b0, make_addr(6'h01, 6'd9, 3'd7), 16'h0, 0);   // kept
    run_txn(1'b0, make_addr(6'h02, 6'd9, 3'd0), 16'h0, 1);   // evicted
    // write hit then read back new data
    run_txn(1'b0, make_addr(6'h04, 6'd20, 3'd2), 16'h0, 1);
    run_txn(1'b1, make_addr(6'h04, 6'd20, 3'd2), 16'hbeef, 0);
    run_txn(1'b0, make_addr(6'h04, 6'd20, 3'd2), 16'h0, 0);
    // write miss does not allocate
    run_txn(1'b1, make_addr(6'h07, 6'd33, 3'd1), 16'h1234, 1);
    run_txn(1'b0, make_addr(6'h07, 6'd33, 3'd1), 16'h0, 1);

    // random mix of 3 tags over 8 sets
    for (int n = 0; n < n_rand; n++) begin
      r    = $random(seed);
      tsel = (r[1:0] == 2'd3) ? 2'd0 : r[1:0];
      we   = (r[3:2] == 2'd0);  // about one in four
      run_txn(we, make_addr({tsel, 4'h5}, {3'b000, r[6:4]}, r[9:7]), r[31:16], -1);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model import cache_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              mem_req,
  input  logic              mem_we,
  input  logic [addr_w-1:0] mem_addr,
  input  logic [word_w-1:0] mem_wdata,
  output logic              mem_ack,
  output logic [word_w-1:0] mem_rdata
);

  logic [word_w-1:0] mem [1 << (addr_w-1)];  // word addressed, byte bit dropped
  int                seed;
  int                rnd;
  int                wait_cnt;                // extra cycles before ack
  logic              busy;                    // beat seen, ack pending

  initial begin
    seed = 58685;
    for (int i = 0; i < (1 << (addr_w-1)); i++) begin
      rnd                  = $random(seed);
      mem[i[addr_w-2:0]]   = rnd[word_w-1:0];
    end
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_ack   <= 1'b0;
      mem_rdata <= '0;
      busy      <= 1'b0;
      wait_cnt  <= 0;
    end else if (mem_ack) begin
      if (!mem_req) mem_ack <= 1'b0;  // four-phase close
    end else if (mem_req && !busy) begin
      wait_cnt <= $random(seed) & 3;  // 0..3 cycles
      busy     <= 1'b1;
    end else if (busy) begin
      if (wait_cnt == 0) begin
        busy    <= 1'b0;
        mem_ack <= 1'b1;
        if (mem_we) mem[mem_addr[addr_w-1:1]] <= mem_wdata;
        else mem_rdata <= mem[mem_addr[addr_w-1:1]];  // held while ack high
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule
